// ==== design/cpuPkg.sv ====
package cpuPkg;

	typedef logic [15:0] wordT; // machine word, also the word address

	typedef logic [1:0] regSelT; // 0 ax, 1 bx, 2 cx, 3 dx

	typedef struct packed {
		logic [11:0] pad;
		regSelT dst; // bits 3:2
		regSelT src; // bits 1:0, also the single-register field
	} regPairT;

	// an operand word is either a plain value or a register pair
	typedef union packed {
		wordT raw;
		regPairT pair;
	} operandU;

	typedef enum wordT {
		opNop  = 16'h0000,
		opMov1 = 16'h0005, // [adr+bp] <= reg
		opMov2 = 16'h0006, // reg <= [adr+bp]
		opMov3 = 16'h0007, // reg <= reg
		opMov4 = 16'h0008, // reg <= immediate
		opPop  = 16'h0009,
		opPush = 16'h000B,
		opAdd  = 16'h000C,
		opAdc  = 16'h000D,
		opSub  = 16'h000E,
		opSuc  = 16'h000F,
		opCmp  = 16'h0014,
		opAnd  = 16'h0015,
		opNeg  = 16'h0016,
		opOr   = 16'h0018,
		opShl  = 16'h0019,
		opShr  = 16'h001A,
		opXor  = 16'h001B,
		opTest = 16'h001C,
		opInt  = 16'h001D,
		opCall = 16'h001E,
		opRet  = 16'h001F,
		opJmp1 = 16'h0020, // relative to bp
		opJc   = 16'h0021,
		opJnc  = 16'h0022,
		opJz   = 16'h0023,
		opJnz  = 16'h0024,
		opMov5 = 16'h002A, // <adr> <= reg
		opMov6 = 16'h002B, // reg <= <adr>
		opJmp2 = 16'h0031  // absolute
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluAdc,
		aluSub,
		aluSuc,
		aluCmp,
		aluAnd,
		aluOr,
		aluXor,
		aluNeg,
		aluShl,
		aluShr
	} aluOpE;

	typedef struct packed {
		logic carry;
		logic zero;
		logic overflow;
	} flagsT;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wordT adr;
		wordT dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		wordT dat;
	} wbRspT;

	typedef struct packed {
		logic valid;
		wordT word;
	} gpuT;

	localparam wordT haltCode = 16'h0001; // INT operand that stops the core

endpackage

// ==== design/wbMaster.sv ====
`timescale 1ns/1ps

module wbMaster import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic we,
	input wordT adr,
	input wordT wdat,
	output logic done,
	output wordT rdat,
	output wbReqT wbOut,
	input wbRspT wbIn
);

	logic busy; // cyc and stb
	logic weQ;
	wordT adrQ;
	wordT datQ;
	logic ackSeen;

	assign ackSeen = busy && wbIn.ack;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			weQ <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				weQ <= we;
			end else if (ackSeen) begin
				busy <= 1'b0; // drops together with done
				weQ <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// address and write data held until ack
	always_ff @(posedge clk) begin
		if (start) begin
			adrQ <= adr;
			datQ <= wdat;
		end
		if (ackSeen)
			rdat <= wbIn.dat; // read word, valid with done
	end

	assign wbOut = '{cyc: busy, stb: busy, we: weQ, adr: adrQ, dat: datQ};

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
	input logic clk,
	input logic arstN,
	input regSelT rdSelA,
	input regSelT rdSelB,
	input regSelT wrSel,
	input logic wrEn,
	input wordT wrData,
	output wordT rdA,
	output wordT rdB,
	input logic bpWrEn,
	input wordT bpIn,
	output wordT bp,
	input logic flagsWrEn,
	input flagsT flagsIn,
	output flagsT flags
);

	wordT gpr [4]; // ax, bx, cx, dx

	assign rdA = gpr[rdSelA];
	assign rdB = gpr[rdSelB];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 4; i++)
				gpr[i] <= '0;
			bp <= '0;
			flags <= '0;
		end else begin
			if (wrEn)
				gpr[wrSel] <= wrData;
			if (bpWrEn)
				bp <= bpIn;
			if (flagsWrEn)
				flags <= flagsIn;
		end
	end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
	input wordT opA,
	input wordT opB,
	input aluOpE op,
	input logic carryIn,
	output wordT result,
	output flagsT flagsOut
);

	logic [16:0] wide; // bit 16 is carry or borrow
	logic isSub;
	logic sameSign;

	always_comb begin
		wide = '0;
		isSub = 1'b0;
		case (op)
			aluAdd: wide = {1'b0, opA} + {1'b0, opB};
			aluAdc: wide = {1'b0, opA} + {1'b0, opB} + 17'(carryIn);
			aluSub, aluCmp: begin
				wide = {1'b0, opA} - {1'b0, opB};
				isSub = 1'b1;
			end
			aluSuc: begin
				wide = {1'b0, opA} - {1'b0, opB} - 17'(carryIn);
				isSub = 1'b1;
			end
			aluAnd: wide = {1'b0, opA & opB};
			aluOr: wide = {1'b0, opA | opB};
			aluXor: wide = {1'b0, opA ^ opB};
			aluNeg: wide = {1'b0, ~opA}; // bitwise inversion
			aluShl: wide = {1'b0, opA << 1};
			aluShr: wide = {1'b0, opA >> 1};
			default: wide = '0;
		endcase
	end

	assign result = wide[15:0];

	// operands agree in sign, inverted sense for subtraction
	assign sameSign = (opA[15] == opB[15]) ^ isSub;

	always_comb begin
		flagsOut.carry = wide[16];
		flagsOut.zero = (result == '0); // cmp zero doubles as TEST equality
		flagsOut.overflow = sameSign && (result[15] != opA[15]);
	end

endmodule

// ==== design/callStack.sv ====
`timescale 1ns/1ps

module callStack import cpuPkg::*; #(
	parameter int StackDepth = 16
) (
	input logic clk,
	input logic arstN,
	input logic push,
	input logic pop,
	input wordT din,
	output wordT top
);

	localparam int PtrW = (StackDepth > 1) ? $clog2(StackDepth) : 1;

	typedef logic [PtrW-1:0] ptrT;

	wordT mem [StackDepth];
	ptrT ptr; // next free entry
	ptrT ptrInc;
	ptrT ptrDec;

	assign ptrInc = (ptr == ptrT'(StackDepth - 1)) ? '0 : ptr + 1'b1;
	assign ptrDec = (ptr == '0) ? ptrT'(StackDepth - 1) : ptr - 1'b1;
	assign top = mem[ptrDec]; // last pushed word

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ptr <= '0;
		else if (push)
			ptr <= ptrInc;
		else if (pop)
			ptr <= ptrDec;
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[ptr] <= din;
	end

endmodule

// ==== design/sequencer.sv ====
`timescale 1ns/1ps

module sequencer import cpuPkg::*; #(
	parameter wordT ResetPc = '0
) (
	input logic clk,
	input logic arstN,
	output logic busStart,
	output logic busWe,
	output wordT busAdr,
	output wordT busWdat,
	input logic busDone,
	input wordT busRdat,
	output regSelT rdSelA,
	output regSelT rdSelB,
	output regSelT wrSel,
	output logic wrEn,
	output wordT wrData,
	input wordT rdB,
	output logic bpWrEn,
	output wordT bpIn,
	input wordT bp,
	output logic flagsWrEn,
	output flagsT flagsIn,
	input flagsT flags,
	output aluOpE aluOp,
	input wordT aluResult,
	input flagsT aluFlags,
	output logic push,
	output logic pop,
	output wordT stackDin,
	input wordT stackTop,
	output gpuT gpu,
	output logic halted
);

	typedef enum logic [2:0] {
		sFetchOp,
		sFetchArg1,
		sFetchArg2,
		sExecute,
		sMemAccess,
		sStack2,
		sDisplay,
		sHalt
	} stateE;

	stateE state;
	wordT pc;
	wordT opcode;
	operandU arg1;
	operandU arg2;
	logic issued; // request out, waiting for done
	logic pairOp; // uses both dst and src
	logic storeOp;
	logic unknownOp;
	logic taken;
	wordT relTarget;
	regSelT selA;

	function automatic logic [1:0] argCount(wordT op);
		case (op)
			opNop, opRet: return 2'd0;
			opMov1, opMov2, opMov4, opMov5, opMov6: return 2'd2;
			default: return 2'd1; // display path has one too
		endcase
	endfunction

	function automatic aluOpE aluDecode(wordT op);
		case (op)
			opAdc: return aluAdc;
			opSub: return aluSub;
			opSuc: return aluSuc;
			opCmp, opTest: return aluCmp;
			opAnd: return aluAnd;
			opOr: return aluOr;
			opXor: return aluXor;
			opNeg: return aluNeg;
			opShl: return aluShl;
			opShr: return aluShr;
			default: return aluAdd;
		endcase
	endfunction

	assign pairOp = opcode inside {opMov3, opAdd, opAdc, opSub, opSuc, opCmp,
		opAnd, opOr, opXor, opTest};
	assign storeOp = opcode inside {opMov1, opMov5};
	assign unknownOp = !(opcode inside {opNop, opMov1, opMov2, opMov3, opMov4, opMov5,
		opMov6, opPush, opPop, opAdd, opAdc, opSub, opSuc, opCmp, opAnd, opOr, opXor,
		opNeg, opShl, opShr, opTest, opInt, opCall, opRet, opJmp1, opJmp2, opJc, opJnc,
		opJz, opJnz});

	// single-register ops name their register in the src field
	assign selA = pairOp ? arg1.pair.dst : arg1.pair.src;
	assign rdSelA = selA;
	assign wrSel = selA;
	assign rdSelB = storeOp ? arg2.pair.src : arg1.pair.src;
	assign aluOp = aluDecode(opcode);
	assign relTarget = arg1.raw + bp;
	assign busWdat = rdB;
	assign busStart = !issued && (state inside {sFetchOp, sFetchArg1, sFetchArg2, sMemAccess});

	always_comb begin
		case (opcode)
			opJc: taken = flags.carry;
			opJnc: taken = !flags.carry;
			opJz: taken = flags.zero;
			opJnz: taken = !flags.zero;
			default: taken = 1'b1; // JMP1
		endcase
	end

	always_comb begin
		busWe = 1'b0;
		busAdr = pc; // instruction fetch
		if (state == sMemAccess) begin
			busWe = storeOp;
			case (opcode)
				opMov1: busAdr = relTarget;
				opMov2: busAdr = arg2.raw + bp;
				opMov5: busAdr = arg1.raw;
				default: busAdr = arg2.raw; // MOV6
			endcase
		end
	end

	always_comb begin
		wrEn = 1'b0;
		wrData = aluResult;
		bpWrEn = 1'b0;
		bpIn = stackTop;
		flagsWrEn = 1'b0;
		flagsIn = aluFlags;
		push = 1'b0;
		pop = 1'b0;
		stackDin = rdB;
		case (state)
			sExecute: begin
				case (opcode)
					opMov3: begin
						wrEn = 1'b1;
						wrData = rdB;
					end
					opMov4: begin
						wrEn = 1'b1;
						wrData = arg2.raw;
					end
					opPush: push = 1'b1;
					opPop: begin
						wrEn = 1'b1;
						wrData = stackTop;
						pop = 1'b1;
					end
					opAdd, opAdc, opSub, opSuc: begin
						wrEn = 1'b1;
						flagsWrEn = 1'b1;
					end
					opCmp: flagsWrEn = 1'b1;
					opTest: begin
						flagsWrEn = 1'b1; // only zero changes
						flagsIn = '{carry: flags.carry, zero: aluFlags.zero,
							overflow: flags.overflow};
					end
					opAnd, opOr, opXor, opNeg, opShl, opShr: wrEn = 1'b1;
					opCall: begin
						push = 1'b1;
						stackDin = bp; // bp goes below the return pc
					end
					opRet: pop = 1'b1;
					default: ;
				endcase
			end
			sMemAccess: begin
				if (busDone && !storeOp) begin
					wrEn = 1'b1;
					wrData = busRdat;
				end
			end
			sStack2: begin
				bpWrEn = 1'b1;
				if (opcode == opCall) begin
					push = 1'b1;
					stackDin = pc; // return address
					bpIn = arg1.raw;
				end else begin
					pop = 1'b1; // RET restores bp
				end
			end
			default: ;
		endcase
	end

	assign gpu = '{valid: (state == sExecute && unknownOp) || state == sDisplay,
		word: (state == sDisplay) ? arg1.raw : opcode};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sFetchOp;
			pc <= ResetPc;
			issued <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (busStart)
				issued <= 1'b1;
			else if (busDone)
				issued <= 1'b0;
			case (state)
				sFetchOp: begin
					if (busDone) begin
						pc <= pc + 1'b1;
						state <= (argCount(busRdat) == 2'd0) ? sExecute : sFetchArg1;
					end
				end
				sFetchArg1: begin
					if (busDone) begin
						pc <= pc + 1'b1;
						state <= (argCount(opcode) == 2'd2) ? sFetchArg2 : sExecute;
					end
				end
				sFetchArg2: begin
					if (busDone) begin
						pc <= pc + 1'b1;
						state <= sExecute;
					end
				end
				sExecute: begin
					state <= unknownOp ? sDisplay : sFetchOp;
					case (opcode)
						opMov1, opMov2, opMov5, opMov6: state <= sMemAccess;
						opJmp2: pc <= arg1.raw;
						opJmp1, opJc, opJnc, opJz, opJnz: begin
							if (taken)
								pc <= relTarget;
						end
						opCall: state <= sStack2;
						opRet: begin
							pc <= stackTop;
							state <= sStack2;
						end
						opInt: begin
							if (arg1.raw == haltCode) begin
								halted <= 1'b1;
								state <= sHalt;
							end
						end
						default: ;
					endcase
				end
				sMemAccess: begin
					if (busDone)
						state <= sFetchOp;
				end
				sStack2: begin
					if (opcode == opCall)
						pc <= relTarget; // old bp still visible here
					state <= sFetchOp;
				end
				sDisplay: state <= sFetchOp;
				default: state <= sHalt; // stays until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (busDone) begin
			case (state)
				sFetchOp: opcode <= busRdat;
				sFetchArg1: arg1.raw <= busRdat;
				sFetchArg2: arg2.raw <= busRdat;
				default: ;
			endcase
		end
	end

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
	parameter int StackDepth = 16,
	parameter wordT ResetPc = '0
) (
	input logic clk,
	input logic arstN,
	input wbRspT wbIn,
	output wbReqT wbOut,
	output gpuT gpu,
	output logic halted
);

	logic busStart, busWe, busDone;
	wordT busAdr, busWdat, busRdat;
	regSelT rdSelA, rdSelB, wrSel;
	logic wrEn, bpWrEn, flagsWrEn;
	wordT wrData, rdA, rdB, bpIn, bp;
	flagsT flagsIn, flags, aluFlags;
	aluOpE aluOp;
	wordT aluResult;
	logic push, pop;
	wordT stackDin, stackTop;

	sequencer #(.ResetPc(ResetPc)) u_sequencer (
		.clk(clk), .arstN(arstN),
		.busStart(busStart), .busWe(busWe), .busAdr(busAdr), .busWdat(busWdat),
		.busDone(busDone), .busRdat(busRdat),
		.rdSelA(rdSelA), .rdSelB(rdSelB), .wrSel(wrSel), .wrEn(wrEn), .wrData(wrData),
		.rdB(rdB), .bpWrEn(bpWrEn), .bpIn(bpIn), .bp(bp),
		.flagsWrEn(flagsWrEn), .flagsIn(flagsIn), .flags(flags),
		.aluOp(aluOp), .aluResult(aluResult), .aluFlags(aluFlags),
		.push(push), .pop(pop), .stackDin(stackDin), .stackTop(stackTop),
		.gpu(gpu), .halted(halted)
	);

	regFile u_regFile (
		.clk(clk), .arstN(arstN),
		.rdSelA(rdSelA), .rdSelB(rdSelB), .wrSel(wrSel), .wrEn(wrEn), .wrData(wrData),
		.rdA(rdA), .rdB(rdB), .bpWrEn(bpWrEn), .bpIn(bpIn), .bp(bp),
		.flagsWrEn(flagsWrEn), .flagsIn(flagsIn), .flags(flags)
	);

	alu u_alu (
		.opA(rdA), .opB(rdB), .op(aluOp), .carryIn(flags.carry),
		.result(aluResult), .flagsOut(aluFlags)
	);

	callStack #(.StackDepth(StackDepth)) u_callStack (
		.clk(clk), .arstN(arstN), .push(push), .pop(pop), .din(stackDin), .top(stackTop)
	);

	wbMaster u_wbMaster (
		.clk(clk), .arstN(arstN), .start(busStart), .we(busWe), .adr(busAdr),
		.wdat(busWdat), .done(busDone), .rdat(busRdat), .wbOut(wbOut), .wbIn(wbIn)
	);

endmodule

// ==== bench/cpuTests.svh ====
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

localparam wordT rAx = 16'd0;
localparam wordT rBx = 16'd1;
localparam wordT rCx = 16'd2;
localparam wordT rDx = 16'd3;

function automatic wordT pair(input wordT dst, input wordT src);
	regPairT p;
	p = '{pad: '0, dst: regSelT'(dst), src: regSelT'(src)};
	return p;
endfunction

task automatic put(input wordT w);
	image[org] = w;
	org++;
endtask

task automatic put2(input wordT op, input wordT a);
	put(op);
	put(a);
endtask

task automatic put3(input wordT op, input wordT a, input wordT b);
	put(op);
	put(a);
	put(b);
endtask

task automatic clearImage();
	for (int i = 0; i < 256; i++)
		image[i] = wordT'(i) * 16'h0101 ^ 16'h5A5A; // every address its own word
	org = 0;
endtask

task automatic loadProgram();
	for (int i = 0; i < 256; i++)
		mem[i] = image[i];
endtask

// reset, load and run until halted rises
task automatic runUntilHalt(input string name);
	int n;
	@(negedge clk);
	arstN = 1'b0;
	loadProgram();
	shown.delete();
	shownAt.delete();
	repeat (4) @(negedge clk);
	if (wbOut.cyc || wbOut.stb || gpu.valid || halted)
		stopRun($sformatf("%s: bus or outputs active during reset", name));
	arstN = 1'b1;
	n = 0;
	while (!halted && n < HaltLimit) begin
		@(negedge clk);
		n++;
	end
	if (!halted)
		stopRun($sformatf("%s: program did not halt within %0d cycles", name, HaltLimit));
endtask

task automatic checkWord(input string name, input wordT exp, input wordT act);
	if (act !== exp)
		stopRun($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
endtask

task automatic checkFlags(input string name, input flagsT exp, input flagsT act);
	if (act !== exp)
		stopRun($sformatf("mismatch in %s: expected %b, actual %b", name, exp, act));
endtask

// stores 1 at base when carry set, 1 at base+1 when zero set
task automatic flagProbe(input wordT base);
	put3(opMov4, rDx, 16'd1);
	put2(opJc, wordT'(org + 5)); // bp is zero in main code
	put3(opMov4, rDx, 16'd0);
	put3(opMov5, base, rDx);
	put3(opMov4, rDx, 16'd1);
	put2(opJz, wordT'(org + 5));
	put3(opMov4, rDx, 16'd0);
	put3(opMov5, wordT'(base + 1), rDx);
endtask

task automatic readFlags(input wordT base, output flagsT f);
	if (mem[base[7:0]] > 16'd1 || mem[base[7:0] + 8'd1] > 16'd1)
		stopRun($sformatf("flag probe at %h was never written", base));
	f.carry = mem[base[7:0]][0];
	f.zero = mem[base[7:0] + 8'd1][0];
	f.overflow = u_dut.u_regFile.flags.overflow; // no jump tests overflow
endtask

task automatic expectArith(input wordT op, input wordT a, input wordT b, input logic cin,
		output wordT res, output flagsT f);
	logic [16:0] full;
	logic subtract;
	subtract = !(op == opAdd || op == opAdc);
	if (!(op == opAdc || op == opSuc))
		cin = 1'b0; // carry in only for ADC and SUC
	if (subtract)
		full = {1'b0, a} - {1'b0, b} - 17'(cin);
	else
		full = {1'b0, a} + {1'b0, b} + 17'(cin);
	res = full[15:0];
	f.carry = full[16]; // borrow for subtraction
	f.zero = (res == 16'd0);
	if (subtract)
		f.overflow = (a[15] != b[15]) && (res[15] != a[15]);
	else
		f.overflow = (a[15] == b[15]) && (res[15] != a[15]);
endtask

task automatic movesRoundTrip();
	wordT a, b, c;
	a = wordT'($urandom);
	b = wordT'($urandom);
	c = wordT'($urandom);
	if (c == b)
		c = ~b; // skipped store must be visible
	clearImage();
	put3(opMov4, rAx, a);
	put3(opMov4, rBx, b);
	put2(opMov3, pair(rCx, rAx));
	put3(opMov5, 16'h00C0, rCx);
	put3(opMov6, rDx, 16'h00C0);
	put3(opMov5, 16'h00C1, rDx);
	put3(opMov5, 16'h00C2, rBx);
	put2(opCall, 16'h0060);
	put2(opJmp2, wordT'(org + 5));
	put3(opMov4, rAx, b); // jumped over
	put3(opMov5, 16'h00C5, rAx);
	put2(opInt, haltCode);
	org = 16'h0060; // routine sees bp = 0x60
	put3(opMov1, 16'h0063, rBx);
	put3(opMov2, rAx, 16'h0064);
	put(opRet);
	image[8'hC4] = c;
	runUntilHalt("moves");
	checkWord("moves MOV3 then MOV5", a, mem[8'hC0]);
	checkWord("moves MOV6 round trip", a, mem[8'hC1]);
	checkWord("moves MOV4 immediate", b, mem[8'hC2]);
	checkWord("moves MOV1 with bp", b, mem[8'hC3]);
	checkWord("moves MOV2 with bp", c, mem[8'hC5]);
endtask

task automatic arithmeticFlags();
	wordT ops [5];
	wordT a, b, res;
	flagsT expF, gotF;
	logic cin;
	ops = '{opAdd, opAdc, opSub, opSuc, opCmp};
	for (int k = 0; k < 5; k++) begin
		for (int round = 0; round < 2; round++) begin
			a = wordT'($urandom);
			b = (round == 0) ? a : wordT'($urandom);
			cin = 1'($urandom_range(1, 0));
			clearImage();
			put3(opMov4, rCx, 16'hFFFF);
			put3(opMov4, rDx, wordT'(cin));
			put2(opAdd, pair(rCx, rDx)); // carry now equals cin
			put3(opMov4, rAx, a);
			put3(opMov4, rBx, b);
			put2(ops[k], pair(rAx, rBx));
			put3(opMov5, 16'h00C0, rAx);
			flagProbe(16'h00C2);
			put2(opInt, haltCode);
			runUntilHalt("arithmetic");
			expectArith(ops[k], a, b, cin, res, expF);
			if (ops[k] == opCmp)
				res = a; // CMP leaves dst alone
			checkWord($sformatf("arithmetic op %h result", ops[k]), res, mem[8'hC0]);
			readFlags(16'h00C2, gotF);
			checkFlags($sformatf("arithmetic op %h flags", ops[k]), expF, gotF);
		end
	end
endtask

task automatic logicOps();
	wordT ops [6];
	wordT want [6];
	wordT a, b;
	flagsT gotF;
	ops = '{opAnd, opOr, opXor, opNeg, opShl, opShr};
	a = wordT'($urandom);
	b = wordT'($urandom);
	if (b == a)
		b = ~a;
	want = '{a & b, a | b, a ^ b, ~a, a << 1, a >> 1};
	clearImage();
	put3(opMov4, rCx, 16'hFFFF);
	put3(opMov4, rDx, 16'h0001);
	put2(opAdd, pair(rCx, rDx)); // carry and zero set, overflow clear
	put3(opMov4, rAx, a);
	put3(opMov4, rBx, b);
	for (int k = 0; k < 6; k++) begin
		put2(opMov3, pair(rCx, rAx));
		if (k < 3)
			put2(ops[k], pair(rCx, rBx));
		else
			put2(ops[k], rCx);
		put3(opMov5, wordT'(16'h00C0 + k), rCx);
	end
	flagProbe(16'h00C8);
	put2(opTest, pair(rAx, rBx));
	flagProbe(16'h00CA);
	put2(opTest, pair(rBx, rBx));
	flagProbe(16'h00CC);
	put2(opInt, haltCode);
	runUntilHalt("logic");
	for (int k = 0; k < 6; k++)
		checkWord($sformatf("logic op %h result", ops[k]), want[k], mem[8'hC0 + k]);
	readFlags(16'h00C8, gotF);
	checkFlags("logic flags kept", '{carry: 1'b1, zero: 1'b1, overflow: 1'b0}, gotF);
	readFlags(16'h00CA, gotF);
	checkFlags("logic TEST unequal", '{carry: 1'b1, zero: 1'b0, overflow: 1'b0}, gotF);
	readFlags(16'h00CC, gotF);
	checkFlags("logic TEST equal", '{carry: 1'b1, zero: 1'b1, overflow: 1'b0}, gotF);
endtask

task automatic stackAndCalls();
	wordT v0, v1, v2, d;
	v0 = wordT'($urandom);
	v1 = wordT'($urandom);
	v2 = wordT'($urandom);
	d = wordT'($urandom) & 16'hFFFE; // never the skipped 0xDEAD
	clearImage();
	put3(opMov4, rAx, v0);
	put3(opMov4, rBx, v1);
	put3(opMov4, rCx, v2);
	put2(opPush, rAx);
	put2(opPush, rBx);
	put2(opPush, rCx);
	put2(opPop, rAx);
	put2(opPop, rBx);
	put2(opPop, rCx);
	put3(opMov5, 16'h00C0, rAx);
	put3(opMov5, 16'h00C1, rBx);
	put3(opMov5, 16'h00C2, rCx);
	put3(opMov4, rDx, 16'h0000);
	put2(opCall, 16'h0060);
	put3(opMov5, 16'h00C3, rDx);
	put3(opMov1, 16'h00C4, rAx); // lands at 0xC4 only with bp restored
	put2(opInt, haltCode);
	org = 16'h0060;
	put3(opMov2, rDx, 16'h0050);
	put2(opJmp1, 16'h0008);
	put3(opMov4, rDx, 16'hDEAD);
	put3(opMov1, 16'h0065, rDx);
	put(opRet);
	image[8'hB0] = d;
	runUntilHalt("stack");
	checkWord("stack first pop", v2, mem[8'hC0]);
	checkWord("stack second pop", v1, mem[8'hC1]);
	checkWord("stack third pop", v0, mem[8'hC2]);
	checkWord("stack value after RET", d, mem[8'hC3]);
	checkWord("stack bp after RET", v2, mem[8'hC4]);
	checkWord("stack routine store", d, mem[8'hC5]);
endtask

task automatic displayAndHalt();
	wordT want [6];
	wordT x0, x1, x2;
	x0 = wordT'($urandom);
	x1 = wordT'($urandom);
	x2 = wordT'($urandom);
	want = '{16'h0040, x0, 16'h00FF, x1, 16'hABCD, x2};
	clearImage();
	put2(16'h0040, x0);
	put(opNop);
	put2(16'h00FF, x1);
	put2(opInt, 16'h0000); // other INT operands run on
	put2(16'hABCD, x2);
	put2(opInt, haltCode);
	runUntilHalt("display");
	checkWord("display word count", 16'd6, wordT'(shown.size()));
	for (int i = 0; i < 6; i++)
		checkWord($sformatf("display word %0d", i), want[i], shown[i]);
	for (int i = 0; i < 3; i++) begin
		if (shownAt[2 * i + 1] != shownAt[2 * i] + 1)
			stopRun($sformatf("display pair %0d not on consecutive cycles", i));
	end
	repeat (20) @(negedge clk);
	if (!halted)
		stopRun("halted dropped before reset");
	checkWord("display words after halt", 16'd6, wordT'(shown.size()));
endtask

`endif

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

	localparam int NumTests = 5;
	localparam int CyclesPerTest = 2000;
	localparam int HaltLimit = 2000; // cycles one program may run

	logic clk = 1'b0;
	logic arstN = 1'b0;
	wbRspT wbIn = '0;
	wbReqT wbOut;
	gpuT gpu;
	logic halted;

	wordT mem [0:255]; // slave memory, word addressed
	wordT image [0:255]; // program under construction
	int org;
	int waitLeft;
	logic pending; // transfer seen, wait states counting
	int cycle = 0;
	wordT shown [$]; // words seen on gpu
	int shownAt [$];

	cpuTop #(
		.StackDepth(16),
		.ResetPc(16'h0000)
	) u_dut (
		.clk(clk),
		.arstN(arstN),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.gpu(gpu),
		.halted(halted)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// slave answers after 0 to 3 wait states
	always @(negedge clk or negedge arstN) begin
		if (!arstN) begin
			wbIn = '0;
			pending = 1'b0;
		end else if (wbIn.ack) begin
			wbIn.ack = 1'b0; // single-cycle ack
		end else if (wbOut.cyc && wbOut.stb) begin
			if (!pending) begin
				pending = 1'b1;
				waitLeft = $urandom_range(3, 0);
			end
			if (waitLeft == 0) begin
				if (wbOut.we)
					mem[wbOut.adr[7:0]] = wbOut.dat;
				wbIn.dat = mem[wbOut.adr[7:0]];
				wbIn.ack = 1'b1;
				pending = 1'b0;
			end else begin
				waitLeft--;
			end
		end
	end

	always @(negedge clk) begin
		cycle++;
		if (gpu.valid) begin
			shown.push_back(gpu.word);
			shownAt.push_back(cycle);
		end
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped at first error");
	endtask

	`include "cpuTests.svh"

	initial begin
		repeat (CyclesPerTest * NumTests) @(posedge clk);
		stopRun("watchdog expired before all tests finished");
	end

	initial begin
		void'($urandom(32'h5bb98f51));
		movesRoundTrip();
		arithmeticFlags();
		logicOps();
		stackAndCalls();
		displayAndHalt();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== cpuTop.f ====
+incdir+bench
design/cpuPkg.sv
design/wbMaster.sv
design/regFile.sv
design/alu.sv
design/callStack.sv
design/sequencer.sv
design/cpuTop.sv
bench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f cpuTop.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
echo "pass line missing from sim.log"
exit 1
